//--- Bender.yml
package:
  name: snake_game

sources:
  - files:
      - logic/snake_pkg.sv
      - logic/display_pkg.sv
      - logic/direction_filter.sv
      - logic/tick_generator.sv
      - logic/snake_engine.sv
      - logic/frame_builder.sv
      - logic/led_scanner.sv
      - logic/snake_game.sv
  - target: simulation
    files:
      - dv/snake_game_properties.sv
      - dv/snake_game_tb.sv

//--- dv/snake_game_properties.sv
`timescale 1ns/1ps

module snake_game_properties (
	input logic               clk,
	input logic               reset,
	input display_pkg::line_t row,
	input snake_pkg::score_t  score,
	input snake_pkg::hearts_t hearts,
	input logic               over
);

	int failures = 0;   // assertion failure count

	// first scan line comes one clock after reset ends
	row_one_hot: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> $onehot(row))
	else begin
		$error("row select is not one-hot: %h", row);
		failures++;
	end

	over_sticky: assert property (@(posedge clk) disable iff (reset)
		$fell(over) |-> $past(reset))
	else begin
		$error("over fell without a reset");
		failures++;
	end

	hearts_no_gain: assert property (@(posedge clk) disable iff (reset)
		(hearts > $past(hearts)) |-> $past(reset))
	else begin
		$error("hearts rose from %h to %h", $past(hearts), hearts);
		failures++;
	end

	// score only counts up in single steps
	score_step: assert property (@(posedge clk) disable iff (reset)
		(score != $past(score)) |-> ((score == $past(score) + 6'd1) || $past(reset)))
	else begin
		$error("score jumped from %h to %h", $past(score), score);
		failures++;
	end

endmodule

bind snake_game snake_game_properties u_properties (
	.clk    (clk),
	.reset  (reset),
	.row    (row),
	.score  (score),
	.hearts (hearts),
	.over   (over)
);

//--- dv/snake_game_tb.sv
`timescale 1ns/1ps

module snake_game_tb;
	import snake_pkg::*;
	import display_pkg::*;

	localparam int DIRECTED_TICKS  = 23;
	localparam int DIRECTED_CYCLES = DIRECTED_TICKS * TICK_BASE + 100;   // plus resets and settling
	localparam int RANDOM_CYCLES   = 4000;
	localparam int TIMEOUT_CYCLES  = 2 * (DIRECTED_CYCLES + RANDOM_CYCLES);

	typedef struct packed {
		dir_t        dir;
		tick_count_t count;
		logic        tick;
		logic        over;
		coord_t      hr, hc, cr, cc, tr, tc, er, ec;
		int          k;          // enemy jump index
		score_t      score;
		hearts_t     hearts;
		logic        blink;
		frame_t      frame;
		scan_idx_t   idx;
		line_t       row;
		line_t       col;
	} model_t;

	logic        clk;
	logic        reset;
	logic        hit;
	logic [3:0]  movement;
	line_t       row;
	line_t       col;
	score_t      score;
	hearts_t     hearts;
	logic        over;
	model_t      model;
	int          reset_edges = 0;
	int          cycles = 0;
	logic [31:0] rand_state;

	snake_game dut (
		.clk      (clk),
		.reset    (reset),
		.hit      (hit),
		.movement (movement),
		.row      (row),
		.col      (col),
		.score    (score),
		.hearts   (hearts),
		.over     (over)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic dir_t reverse_heading(dir_t d);
		case (d)
			DIR_UP:    return DIR_DOWN;
			DIR_DOWN:  return DIR_UP;
			DIR_LEFT:  return DIR_RIGHT;
			DIR_RIGHT: return DIR_LEFT;
			default:   return DIR_NONE;
		endcase
	endfunction

	function automatic logic close_to(coord_t a, coord_t b);
		int d;
		d = int'(a) - int'(b);
		if (d < 0)
			d = -d;
		return d <= HIT_RANGE;
	endfunction

	function automatic frame_t draw(model_t m);
		frame_t f;
		f = '0;
		f[m.hr * GRID_SIZE + m.hc] = 1'b1;
		f[m.cr * GRID_SIZE + m.cc] = 1'b1;
		f[m.tr * GRID_SIZE + m.tc] = 1'b1;
		if (m.blink)
			f[m.er * GRID_SIZE + m.ec] = 1'b1;   // enemy only in its lit phase
		return f;
	endfunction

	// whole game one clock ahead
	function automatic model_t next_model(model_t m, logic [3:0] mv, logic h, logic rst);
		model_t  n;
		coord_t  nr;
		coord_t  nc;
		logic    wall;
		hearts_t left;
		n = m;
		n.frame = draw(m);   // drawn from the old state, reset or not
		if (rst) begin
			n.dir    = DIR_NONE;
			n.count  = tick_count_t'(TICK_BASE);
			n.tick   = 1'b0;
			n.over   = 1'b0;
			n.hr     = coord_t'(HEAD_ROW_INIT);
			n.hc     = coord_t'(HEAD_COL_INIT);
			n.cr     = coord_t'(HEAD_ROW_INIT);
			n.cc     = coord_t'(CENTER_COL_INIT);
			n.tr     = coord_t'(HEAD_ROW_INIT);
			n.tc     = coord_t'(TAIL_COL_INIT);
			n.er     = coord_t'(ENEMY_ROW_INIT);
			n.ec     = coord_t'(ENEMY_COL_INIT);
			n.k      = ENEMY_IDX_INIT;
			n.score  = '0;
			n.hearts = hearts_t'(HEARTS_INIT);
			n.blink  = 1'b0;
			n.idx    = '0;
			n.row    = '0;
			n.col    = '0;
			return n;
		end
		if ($onehot(mv) && mv != reverse_heading(m.dir))
			n.dir = dir_t'(mv);
		n.tick  = (m.count == 8'd1);
		n.count = n.tick ? tick_count_t'(TICK_BASE - SPEED_STEP * m.score) : m.count - 8'd1;
		if (!m.over) begin
			nr   = m.hr;
			nc   = m.hc;
			wall = 1'b0;
			case (m.dir)
				DIR_UP: begin
					wall = (m.hr == 0);
					nr   = m.hr - 4'd1;
				end
				DIR_DOWN: begin
					wall = (m.hr == 15);
					nr   = m.hr + 4'd1;
				end
				DIR_LEFT: begin
					wall = (m.hc == 0);
					nc   = m.hc - 4'd1;
				end
				DIR_RIGHT: begin
					wall = (m.hc == 15);
					nc   = m.hc + 4'd1;
				end
				default: ;
			endcase
			if (m.tick && m.dir != DIR_NONE) begin
				left = wall ? 2'd0 : (nr == m.er && nc == m.ec) ? m.hearts - 2'd1 : m.hearts;
				n.hearts = left;
				if (!wall) begin
					{n.hr, n.hc} = {nr, nc};
					{n.cr, n.cc} = {m.hr, m.hc};
					{n.tr, n.tc} = {m.cr, m.cc};
				end
				n.over = (left == 0);
			end
			if (h && m.score < SCORE_MAX && close_to(m.hr, m.er) && close_to(m.hc, m.ec)) begin
				n.score = m.score + 6'd1;
				n.er    = coord_t'((ENEMY_MULT * m.k) % ENEMY_SPAN + ENEMY_OFFSET);
				n.ec    = coord_t'((ENEMY_MULT * (m.k + 1)) % ENEMY_SPAN + ENEMY_OFFSET);
				n.k     = m.k + 1;
			end
		end
		if (m.tick && !m.over)
			n.blink = ~m.blink;
		n.row = line_t'(1) << (GRID_SIZE - 1 - m.idx);
		n.col = m.frame[m.idx * GRID_SIZE +: GRID_SIZE];
		n.idx = m.idx + 4'd1;
		return n;
	endfunction

	task automatic stop_with_failure();
		$display("Errors found");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_score(input score_t got, input score_t exp);
		if (got !== exp) begin
			$display("ERROR score: got %h, expected %h", got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_hearts(input hearts_t got, input hearts_t exp);
		if (got !== exp) begin
			$display("ERROR hearts: got %h, expected %h", got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_line(input string name, input line_t got, input line_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// compare against the model, then step it with this edge's inputs
	always @(posedge clk) begin
		if (dut.u_properties.failures != 0) begin
			$display("a concurrent assertion on the DUT failed");
			stop_with_failure();
		end
		if (reset_edges >= 2) begin
			check_score(score, model.score);
			check_hearts(hearts, model.hearts);
			check_flag("over", over, model.over);
			check_line("row", row, model.row);
			check_line("col", col, model.col);
		end
		if (reset && reset_edges < 2)
			reset_edges++;
		model = next_model(model, movement, hit, reset);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	task automatic apply_reset();
		reset    = 1'b1;
		hit      = 1'b0;
		movement = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic press(input logic [3:0] mv);
		@(negedge clk);
		movement = mv;
		@(negedge clk);
		movement = '0;
	endtask

	task automatic press_hit();
		@(negedge clk);
		hit = 1'b1;
		@(negedge clk);
		hit = 1'b0;
	endtask

	// returns on the negedge where tick is high so the move lands on the next edge
	task automatic wait_ticks(input int n);
		repeat (n) begin
			@(negedge clk);
			while (!model.tick)
				@(negedge clk);
		end
	endtask

	task automatic settle();
		repeat (2) @(negedge clk);
	endtask

	initial begin
		rand_state = 32'h0ecfbda6;
		apply_reset();
		wait_ticks(3);            // standing snake, enemy blinking
		press(DIR_RIGHT);
		wait_ticks(2);            // head at (3,5)
		press(DIR_LEFT);          // u-turn is ignored
		wait_ticks(1);
		press(DIR_DOWN);
		wait_ticks(1);            // head at (4,6), enemy at (5,8)
		press_hit();
		check_score(score, score_t'(1));
		wait_ticks(1);            // head at (5,6), enemy now at (11,2)
		press_hit();
		check_score(score, score_t'(1));
		wait_ticks(6);
		press(DIR_LEFT);          // turn on row 11
		wait_ticks(4);            // lands on the enemy
		settle();
		check_hearts(hearts, hearts_t'(2));
		check_flag("over", over, 1'b0);
		wait_ticks(3);            // runs into the left wall
		settle();
		check_hearts(hearts, hearts_t'(0));
		check_flag("over", over, 1'b1);
		press(DIR_UP);
		press_hit();
		wait_ticks(2);
		press(DIR_RIGHT);
		press_hit();
		settle();
		check_hearts(hearts, hearts_t'(0));
		check_flag("over", over, 1'b1);
		check_score(score, score_t'(1));
		apply_reset();
		settle();
		check_score(score, score_t'(0));
		check_hearts(hearts, hearts_t'(HEARTS_INIT));
		check_flag("over", over, 1'b0);
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			@(negedge clk);
			rand_state = lcg_next(rand_state);
			reset = over;   // restart a finished game
			hit = (rand_state[17:16] == 2'd0);
			if (rand_state[23:20] < 4'd3)
				movement = 4'b0001 << rand_state[25:24];
			else if (rand_state[23:20] == 4'd3)
				movement = rand_state[29:26];
			else
				movement = '0;
		end
		if (dut.u_properties.failures == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("concurrent assertions failed %0d times", dut.u_properties.failures);
			stop_with_failure();
		end
	end

endmodule

//--- logic/direction_filter.sv
`timescale 1ns/1ps

module direction_filter (
	input  logic              clk,
	input  logic              reset,
	input  logic [3:0]        movement,
	output snake_pkg::dir_t   dir
);
	import snake_pkg::*;

	dir_t press;
	logic accept;

	// heading that would turn the snake back on itself
	function automatic dir_t reverse_of(dir_t d);
		case (d)
			DIR_UP:    return DIR_DOWN;
			DIR_DOWN:  return DIR_UP;
			DIR_LEFT:  return DIR_RIGHT;
			DIR_RIGHT: return DIR_LEFT;
			default:   return DIR_NONE;
		endcase
	endfunction

	assign press = dir_t'(movement);

	// one button only, and not a u-turn
	assign accept = $onehot(movement) && (press != reverse_of(dir));

	always_ff @(posedge clk) begin
		if (reset) begin
			dir <= DIR_NONE;   // snake stands still until a press
		end else if (accept) begin
			dir <= press;
		end
	end

endmodule

//--- logic/display_pkg.sv
package display_pkg;

	localparam int GRID_SIZE = 16;

	// bit row*16+col is the cell at (row, col)
	typedef logic [GRID_SIZE*GRID_SIZE-1:0] frame_t;

	// one matrix line, or a one-hot row select
	typedef logic [GRID_SIZE-1:0] line_t;

	typedef logic [3:0] scan_idx_t;

endpackage

//--- logic/frame_builder.sv
`timescale 1ns/1ps

module frame_builder (
	input  logic                clk,
	input  logic                reset,
	input  logic                tick,
	input  logic                over,
	input  snake_pkg::coord_t   head_row,
	input  snake_pkg::coord_t   head_col,
	input  snake_pkg::coord_t   center_row,
	input  snake_pkg::coord_t   center_col,
	input  snake_pkg::coord_t   tail_row,
	input  snake_pkg::coord_t   tail_col,
	input  snake_pkg::coord_t   enemy_row,
	input  snake_pkg::coord_t   enemy_col,
	output display_pkg::frame_t frame
);
	import display_pkg::*;

	logic   blink;        // enemy visible when set
	frame_t next_frame;

	always_ff @(posedge clk) begin
		if (reset)
			blink <= 1'b0;
		else if (tick && !over)
			blink <= ~blink;   // frozen once the game ends
	end

	always_comb begin
		next_frame = '0;
		next_frame[head_row * GRID_SIZE + head_col]     = 1'b1;
		next_frame[center_row * GRID_SIZE + center_col] = 1'b1;
		next_frame[tail_row * GRID_SIZE + tail_col]     = 1'b1;
		if (blink)
			next_frame[enemy_row * GRID_SIZE + enemy_col] = 1'b1;
	end

	always_ff @(posedge clk) begin
		frame <= next_frame;
	end

endmodule

//--- logic/led_scanner.sv
`timescale 1ns/1ps

module led_scanner (
	input  logic                clk,
	input  logic                reset,
	input  display_pkg::frame_t frame,
	output display_pkg::line_t  row,
	output display_pkg::line_t  col
);
	import display_pkg::*;

	scan_idx_t idx;

	always_ff @(posedge clk) begin
		if (reset)
			idx <= '0;
		else
			idx <= idx + 4'd1;   // wraps after 15
	end

	// row 0 of the frame sits on the top select line
	always_ff @(posedge clk) begin
		if (reset) begin
			row <= '0;
			col <= '0;
		end else begin
			row <= line_t'(1) << (GRID_SIZE - 1 - idx);
			col <= frame[idx * GRID_SIZE +: GRID_SIZE];
		end
	end

endmodule

//--- logic/snake_engine.sv
`timescale 1ns/1ps

module snake_engine (
	input  logic               clk,
	input  logic               reset,
	input  logic               tick,
	input  logic               hit,
	input  snake_pkg::dir_t    dir,
	output snake_pkg::coord_t  head_row,
	output snake_pkg::coord_t  head_col,
	output snake_pkg::coord_t  center_row,
	output snake_pkg::coord_t  center_col,
	output snake_pkg::coord_t  tail_row,
	output snake_pkg::coord_t  tail_col,
	output snake_pkg::coord_t  enemy_row,
	output snake_pkg::coord_t  enemy_col,
	output snake_pkg::score_t  score,
	output snake_pkg::hearts_t hearts,
	output logic               over
);
	import snake_pkg::*;

	game_state_t state;
	logic [7:0]  jump_idx;    // enemy jump index k

	coord_t  next_row;
	coord_t  next_col;
	logic    at_wall;
	logic    moving;
	logic    eats_enemy;
	logic    hit_ok;
	hearts_t hearts_after;

	// distance on one axis within hit range
	function automatic logic near(coord_t a, coord_t b);
		coord_t d;
		d = (a > b) ? a - b : b - a;
		return d <= HIT_RANGE;
	endfunction

	// head target for this heading, and wall check
	always_comb begin
		next_row = head_row;
		next_col = head_col;
		at_wall  = 1'b0;
		case (dir)
			DIR_UP: begin
				at_wall  = (head_row == '0);
				next_row = head_row - 4'd1;
			end
			DIR_DOWN: begin
				at_wall  = (head_row == '1);
				next_row = head_row + 4'd1;
			end
			DIR_LEFT: begin
				at_wall  = (head_col == '0);
				next_col = head_col - 4'd1;
			end
			DIR_RIGHT: begin
				at_wall  = (head_col == '1);
				next_col = head_col + 4'd1;
			end
			default: ;
		endcase
	end

	assign moving     = tick && (dir != DIR_NONE);
	assign eats_enemy = (next_row == enemy_row) && (next_col == enemy_col); // old enemy cell

	// wall takes every heart, enemy takes one
	always_comb begin
		if (at_wall)
			hearts_after = '0;
		else if (eats_enemy)
			hearts_after = hearts - 2'd1;
		else
			hearts_after = hearts;
	end

	assign hit_ok = hit && (score < SCORE_MAX)
		&& near(head_row, enemy_row) && near(head_col, enemy_col);

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= GAME_PLAY;
			head_row   <= coord_t'(HEAD_ROW_INIT);
			head_col   <= coord_t'(HEAD_COL_INIT);
			center_row <= coord_t'(HEAD_ROW_INIT);
			center_col <= coord_t'(CENTER_COL_INIT);
			tail_row   <= coord_t'(HEAD_ROW_INIT);
			tail_col   <= coord_t'(TAIL_COL_INIT);
			enemy_row  <= coord_t'(ENEMY_ROW_INIT);
			enemy_col  <= coord_t'(ENEMY_COL_INIT);
			jump_idx   <= 8'(ENEMY_IDX_INIT);
			score      <= '0;
			hearts     <= hearts_t'(HEARTS_INIT);
		end else if (state == GAME_PLAY) begin
			if (moving) begin
				hearts <= hearts_after;
				if (!at_wall) begin
					head_row   <= next_row;
					head_col   <= next_col;
					center_row <= head_row;
					center_col <= head_col;
					tail_row   <= center_row;
					tail_col   <= center_col;
				end
				if (hearts_after == '0)
					state <= GAME_OVER;
			end
			// hit is checked every clock, not only on ticks
			if (hit_ok) begin
				score     <= score + 6'd1;
				enemy_row <= coord_t'((ENEMY_MULT * jump_idx) % ENEMY_SPAN + ENEMY_OFFSET);
				enemy_col <= coord_t'((ENEMY_MULT * (jump_idx + 1)) % ENEMY_SPAN
					+ ENEMY_OFFSET);
				jump_idx  <= jump_idx + 8'd1;
			end
		end
	end

	assign over = (state == GAME_OVER);

endmodule

//--- logic/snake_game.sv
`timescale 1ns/1ps

module snake_game (
	input  logic               clk,
	input  logic               reset,
	input  logic               hit,
	input  logic [3:0]         movement,   // up, down, left, right one-hot
	output display_pkg::line_t row,
	output display_pkg::line_t col,
	output snake_pkg::score_t  score,
	output snake_pkg::hearts_t hearts,
	output logic               over
);

	snake_pkg::dir_t     dir;
	logic                tick;
	snake_pkg::coord_t   head_row;
	snake_pkg::coord_t   head_col;
	snake_pkg::coord_t   center_row;
	snake_pkg::coord_t   center_col;
	snake_pkg::coord_t   tail_row;
	snake_pkg::coord_t   tail_col;
	snake_pkg::coord_t   enemy_row;
	snake_pkg::coord_t   enemy_col;
	display_pkg::frame_t frame;

	direction_filter u_direction_filter (
		.clk      (clk),
		.reset    (reset),
		.movement (movement),
		.dir      (dir)
	);

	tick_generator u_tick_generator (
		.clk   (clk),
		.reset (reset),
		.score (score),
		.tick  (tick)
	);

	snake_engine u_snake_engine (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.hit        (hit),
		.dir        (dir),
		.head_row   (head_row),
		.head_col   (head_col),
		.center_row (center_row),
		.center_col (center_col),
		.tail_row   (tail_row),
		.tail_col   (tail_col),
		.enemy_row  (enemy_row),
		.enemy_col  (enemy_col),
		.score      (score),
		.hearts     (hearts),
		.over       (over)
	);

	frame_builder u_frame_builder (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.over       (over),
		.head_row   (head_row),
		.head_col   (head_col),
		.center_row (center_row),
		.center_col (center_col),
		.tail_row   (tail_row),
		.tail_col   (tail_col),
		.enemy_row  (enemy_row),
		.enemy_col  (enemy_col),
		.frame      (frame)
	);

	led_scanner u_led_scanner (
		.clk   (clk),
		.reset (reset),
		.frame (frame),
		.row   (row),
		.col   (col)
	);

endmodule

//--- logic/snake_pkg.sv
package snake_pkg;

	typedef logic [3:0] coord_t;      // board row or column
	typedef logic [5:0] score_t;
	typedef logic [1:0] hearts_t;
	typedef logic [7:0] tick_count_t;

	// matches the one-hot movement buttons
	typedef enum logic [3:0] {
		DIR_NONE  = 4'd0,
		DIR_UP    = 4'd1,
		DIR_DOWN  = 4'd2,
		DIR_LEFT  = 4'd4,
		DIR_RIGHT = 4'd8
	} dir_t;

	typedef enum logic {
		GAME_PLAY,
		GAME_OVER
	} game_state_t;

	// start position with the body on row 3
	localparam int HEAD_ROW_INIT   = 3;
	localparam int HEAD_COL_INIT   = 3;
	localparam int CENTER_COL_INIT = 2;
	localparam int TAIL_COL_INIT   = 1;
	localparam int ENEMY_ROW_INIT  = 5;
	localparam int ENEMY_COL_INIT  = 8;

	localparam int HEARTS_INIT = 3;
	localparam int HIT_RANGE   = 2;   // per axis

	// enemy jumps to (mult * k mod span) + offset
	localparam int ENEMY_MULT     = 123;
	localparam int ENEMY_SPAN     = 12;
	localparam int ENEMY_OFFSET   = 2;
	localparam int ENEMY_IDX_INIT = 123;

	localparam int TICK_BASE  = 128;
	localparam int SPEED_STEP = 5;
	localparam int SCORE_MAX  = 20;   // keeps the period at 28 or more
endpackage

//--- logic/tick_generator.sv
`timescale 1ns/1ps

module tick_generator (
	input  logic              clk,
	input  logic              reset,
	input  snake_pkg::score_t score,
	output logic              tick
);
	import snake_pkg::*;

	tick_count_t count;
	tick_count_t period;

	// faster game as the score goes up
	assign period = tick_count_t'(TICK_BASE - SPEED_STEP * score);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= tick_count_t'(TICK_BASE);
			tick  <= 1'b0;
		end else if (count == tick_count_t'(1)) begin
			count <= period;   // score sampled at reload
			tick  <= 1'b1;
		end else begin
			count <= count - tick_count_t'(1);
			tick  <= 1'b0;
		end
	end

endmodule

//--- snake_game.f
logic/snake_pkg.sv
logic/display_pkg.sv
logic/direction_filter.sv
logic/tick_generator.sv
logic/snake_engine.sv
logic/frame_builder.sv
logic/led_scanner.sv
logic/snake_game.sv
dv/snake_game_properties.sv
dv/snake_game_tb.sv
